//--- include/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// reorder buffer depth, power of two
`define ROB_LEN 8

// datapath width
`define XLEN 32

// architectural registers
`define REG_LEN 32

`endif

//--- source/rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

    typedef logic [$clog2(`ROB_LEN)-1:0] rob_tag_t;
    typedef logic [$clog2(`ROB_LEN):0]   rob_cnt_t;   // one extra bit so full fits
    typedef logic [$clog2(`REG_LEN)-1:0] reg_idx_t;
    typedef logic [`XLEN-1:0]            data_t;

    // alu and load write a destination, store and branch do not
    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store,
        op_branch
    } opcode_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t dest_reg_idx;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
    } id_packet_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } cdb_packet_t;

    // value is zero while pending
    typedef struct packed {
        logic     pending;
        rob_tag_t tag;
        data_t    value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        operand_t rs1;
        operand_t rs2;
    } rs_packet_t;

    typedef struct packed {
        logic     busy;
        logic     ready;
        logic     writes_reg;
        reg_idx_t dest_reg_idx;
        data_t    value;
    } rob_entry_t;

    typedef struct packed {
        logic     valid;
        logic     writes_reg;
        rob_tag_t tag;
        reg_idx_t dest_reg_idx;
        data_t    value;
    } retire_packet_t;

endpackage

//--- source/rename_stage.sv
`include "rob_params.svh"

module rename_stage (
    input  logic                    clock,
    input  logic                    reset,
    input  rob_pkg::id_packet_t     id_in,
    input  logic                    full,
    input  rob_pkg::rob_tag_t       alloc_tag,
    input  logic                    rob_ready1,
    input  logic                    rob_ready2,
    input  rob_pkg::data_t          rob_value1,
    input  rob_pkg::data_t          rob_value2,
    input  rob_pkg::data_t          rf_data1,
    input  rob_pkg::data_t          rf_data2,
    input  rob_pkg::retire_packet_t retire,
    output logic                    alloc,
    output logic                    alloc_writes_reg,
    output rob_pkg::reg_idx_t       alloc_dest,
    output rob_pkg::rob_tag_t       lookup_tag1,
    output rob_pkg::rob_tag_t       lookup_tag2,
    output rob_pkg::reg_idx_t       rf_idx1,
    output rob_pkg::reg_idx_t       rf_idx2,
    output rob_pkg::rs_packet_t     rs_out
);
    import rob_pkg::*;

    logic     map_valid [`REG_LEN];
    rob_tag_t map_tag   [`REG_LEN];   // producer of the newest value

    logic dest_writes;

    assign dest_writes = (id_in.opcode == op_alu || id_in.opcode == op_load)
                         && (id_in.dest_reg_idx != '0);

    assign alloc            = id_in.valid && !full;
    assign alloc_writes_reg = dest_writes;
    assign alloc_dest       = id_in.dest_reg_idx;

    assign lookup_tag1 = map_tag[id_in.rs1_idx];
    assign lookup_tag2 = map_tag[id_in.rs2_idx];
    assign rf_idx1     = id_in.rs1_idx;
    assign rf_idx2     = id_in.rs2_idx;

    // three way operand select, no cdb bypass
    always_comb begin
        rs_out.valid = alloc;
        rs_out.tag   = alloc_tag;

        rs_out.rs1 = '{pending: 1'b0, tag: '0, value: rf_data1};
        if (map_valid[id_in.rs1_idx]) begin
            if (rob_ready1)
                rs_out.rs1.value = rob_value1;
            else
                rs_out.rs1 = '{pending: 1'b1, tag: lookup_tag1, value: '0};
        end

        rs_out.rs2 = '{pending: 1'b0, tag: '0, value: rf_data2};
        if (map_valid[id_in.rs2_idx]) begin
            if (rob_ready2)
                rs_out.rs2.value = rob_value2;
            else
                rs_out.rs2 = '{pending: 1'b1, tag: lookup_tag2, value: '0};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_LEN; i++)
                map_valid[i] <= 1'b0;
        end else begin
            // retire clears only if no younger writer took the register
            if (retire.valid && retire.writes_reg
                && map_tag[retire.dest_reg_idx] == retire.tag)
                map_valid[retire.dest_reg_idx] <= 1'b0;
            if (alloc && dest_writes)
                map_valid[id_in.dest_reg_idx] <= 1'b1;   // later write, dispatch wins
        end
    end

    always_ff @(posedge clock) begin
        if (alloc && dest_writes)
            map_tag[id_in.dest_reg_idx] <= alloc_tag;
    end

endmodule

//--- source/rob_entry.sv
module rob_entry (
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc,
    input  logic                complete,
    input  logic                clear,
    input  logic                writes_reg_in,
    input  rob_pkg::reg_idx_t   dest_reg_idx_in,
    input  rob_pkg::data_t      cdb_value,
    output rob_pkg::rob_entry_t entry
);
    import rob_pkg::*;

    logic     busy;
    logic     ready;    // result has come back on the cdb
    logic     writes_reg;
    reg_idx_t dest_reg_idx;
    data_t    value;

    // alloc beats complete beats clear
    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            ready <= 1'b0;
        end else if (alloc) begin
            busy  <= 1'b1;
            ready <= 1'b0;
        end else if (complete) begin
            ready <= 1'b1;
        end else if (clear) begin
            busy  <= 1'b0;
            ready <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            writes_reg   <= writes_reg_in;
            dest_reg_idx <= dest_reg_idx_in;
            value        <= '0;
        end else if (complete) begin
            value <= cdb_value;
        end
    end

    assign entry = '{busy: busy, ready: ready, writes_reg: writes_reg,
                     dest_reg_idx: dest_reg_idx, value: value};

endmodule

//--- source/rob.sv
`include "rob_params.svh"

module rob (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    alloc,
    input  logic                    alloc_writes_reg,
    input  rob_pkg::reg_idx_t       alloc_dest,
    input  rob_pkg::cdb_packet_t    cdb_in,
    input  rob_pkg::rob_tag_t       lookup_tag1,
    input  rob_pkg::rob_tag_t       lookup_tag2,
    output rob_pkg::rob_tag_t       alloc_tag,
    output logic                    full,
    output logic                    lookup_ready1,
    output logic                    lookup_ready2,
    output rob_pkg::data_t          lookup_value1,
    output rob_pkg::data_t          lookup_value2,
    output rob_pkg::retire_packet_t retire_out
);
    import rob_pkg::*;

    rob_tag_t head;   // oldest in flight
    rob_tag_t tail;   // next free slot
    rob_cnt_t count;

    logic [`ROB_LEN-1:0] alloc_vec;
    logic [`ROB_LEN-1:0] complete_vec;
    logic [`ROB_LEN-1:0] clear_vec;
    rob_entry_t          slots [`ROB_LEN];

    logic retire;

    assign alloc_tag = tail;
    assign full      = (count == rob_cnt_t'(`ROB_LEN));

    // head retires once its result is in
    assign retire = slots[head].busy && slots[head].ready;

    // one-hot strobes into the slot array
    always_comb begin
        alloc_vec    = '0;
        complete_vec = '0;
        clear_vec    = '0;
        if (alloc)
            alloc_vec[tail] = 1'b1;
        if (cdb_in.valid)
            complete_vec[cdb_in.tag] = 1'b1;
        if (retire)
            clear_vec[head] = 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc)
                tail <= tail + 1'b1;   // wraps, depth is a power of two
            if (retire)
                head <= head + 1'b1;
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    for (genvar i = 0; i < `ROB_LEN; i++) begin : g_slot
        rob_entry u_entry (
            .clock           (clock),
            .reset           (reset),
            .alloc           (alloc_vec[i]),
            .complete        (complete_vec[i]),
            .clear           (clear_vec[i]),
            .writes_reg_in   (alloc_writes_reg),
            .dest_reg_idx_in (alloc_dest),
            .cdb_value       (cdb_in.value),
            .entry           (slots[i])
        );
    end

    // operand read ports for rename
    assign lookup_ready1 = slots[lookup_tag1].ready;
    assign lookup_ready2 = slots[lookup_tag2].ready;
    assign lookup_value1 = slots[lookup_tag1].value;
    assign lookup_value2 = slots[lookup_tag2].value;

    always_comb begin
        retire_out.valid        = retire;
        retire_out.writes_reg   = slots[head].writes_reg;
        retire_out.tag          = head;
        retire_out.dest_reg_idx = slots[head].dest_reg_idx;
        retire_out.value        = slots[head].value;
    end

endmodule

//--- source/arch_regfile.sv
`include "rob_params.svh"

module arch_regfile (
    input  logic                    clock,
    input  logic                    reset,
    input  rob_pkg::retire_packet_t retire,
    input  rob_pkg::reg_idx_t       rd_idx1,
    input  rob_pkg::reg_idx_t       rd_idx2,
    output rob_pkg::data_t          rd_data1,
    output rob_pkg::data_t          rd_data2
);
    import rob_pkg::*;

    data_t regs [`REG_LEN];

    logic wr_en;

    // x0 never written
    assign wr_en = retire.valid && retire.writes_reg && (retire.dest_reg_idx != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_LEN; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[retire.dest_reg_idx] <= retire.value;
        end
    end

    // no write-through, rename handles it via the map table
    assign rd_data1 = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
    assign rd_data2 = (rd_idx2 == '0) ? '0 : regs[rd_idx2];

endmodule

//--- source/rob_top.sv
module rob_top (
    input  logic                    clock,
    input  logic                    reset,
    input  rob_pkg::id_packet_t     id_in,
    input  rob_pkg::cdb_packet_t    cdb_in,
    output logic                    stall,
    output rob_pkg::rs_packet_t     rs_out,
    output rob_pkg::retire_packet_t retire_out
);
    import rob_pkg::*;

    logic     alloc;
    logic     alloc_writes_reg;
    reg_idx_t alloc_dest;
    rob_tag_t alloc_tag;
    logic     full;
    rob_tag_t lookup_tag1;
    rob_tag_t lookup_tag2;
    logic     rob_ready1;
    logic     rob_ready2;
    data_t    rob_value1;
    data_t    rob_value2;
    reg_idx_t rf_idx1;
    reg_idx_t rf_idx2;
    data_t    rf_data1;
    data_t    rf_data2;

    assign stall = full;

    rename_stage u_rename (
        .clock            (clock),
        .reset            (reset),
        .id_in            (id_in),
        .full             (full),
        .alloc_tag        (alloc_tag),
        .rob_ready1       (rob_ready1),
        .rob_ready2       (rob_ready2),
        .rob_value1       (rob_value1),
        .rob_value2       (rob_value2),
        .rf_data1         (rf_data1),
        .rf_data2         (rf_data2),
        .retire           (retire_out),
        .alloc            (alloc),
        .alloc_writes_reg (alloc_writes_reg),
        .alloc_dest       (alloc_dest),
        .lookup_tag1      (lookup_tag1),
        .lookup_tag2      (lookup_tag2),
        .rf_idx1          (rf_idx1),
        .rf_idx2          (rf_idx2),
        .rs_out           (rs_out)
    );

    rob u_rob (
        .clock            (clock),
        .reset            (reset),
        .alloc            (alloc),
        .alloc_writes_reg (alloc_writes_reg),
        .alloc_dest       (alloc_dest),
        .cdb_in           (cdb_in),
        .lookup_tag1      (lookup_tag1),
        .lookup_tag2      (lookup_tag2),
        .alloc_tag        (alloc_tag),
        .full             (full),
        .lookup_ready1    (rob_ready1),
        .lookup_ready2    (rob_ready2),
        .lookup_value1    (rob_value1),
        .lookup_value2    (rob_value2),
        .retire_out       (retire_out)
    );

    arch_regfile u_regfile (
        .clock    (clock),
        .reset    (reset),
        .retire   (retire_out),
        .rd_idx1  (rf_idx1),
        .rd_idx2  (rf_idx2),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2)
    );

endmodule

//--- tests/rob_chk.sv
`include "rob_params.svh"

module rob_chk (
    input logic                    clock,
    input logic                    reset,
    input rob_pkg::id_packet_t     id_in,
    input rob_pkg::cdb_packet_t    cdb_in,
    input logic                    stall,
    input rob_pkg::rs_packet_t     rs_out,
    input rob_pkg::retire_packet_t retire_out
);
    timeunit 1ns;
    timeprecision 1ns;
    import rob_pkg::*;

    int       error_count = 0;
    int       occupancy;
    rob_tag_t next_retire;
    rob_tag_t next_alloc;   // expected tail
    logic     done      [`ROB_LEN];   // result seen on the cdb
    data_t    cdb_value [`ROB_LEN];
    logic     writes    [`ROB_LEN];
    reg_idx_t dest      [`ROB_LEN];
    logic     map_valid [`REG_LEN];
    rob_tag_t map_tag   [`REG_LEN];
    data_t    regs      [`REG_LEN];

    logic     new_writes;
    logic     ret_done;
    data_t    ret_value;
    logic     exp_retire;
    operand_t exp_rs1;
    operand_t exp_rs2;

    // what rename should hand out for register r
    function automatic operand_t predict(reg_idx_t r);
        operand_t op;
        op = '{pending: 1'b0, tag: '0, value: regs[r]};
        if (map_valid[r] && !done[map_tag[r]])
            op = '{pending: 1'b1, tag: map_tag[r], value: '0};
        else if (map_valid[r])
            op.value = cdb_value[map_tag[r]];
        return op;
    endfunction

    function automatic logic operand_ok(operand_t exp, operand_t act);
        if (exp.pending)
            return act.pending && act.tag == exp.tag && act.value == '0;
        return !act.pending && act.value == exp.value;   // tag is don't care here
    endfunction

    assign new_writes = (id_in.opcode == op_alu || id_in.opcode == op_load)
                        && id_in.dest_reg_idx != '0;
    assign ret_done   = done[retire_out.tag];
    assign ret_value  = cdb_value[retire_out.tag];
    assign exp_retire = (occupancy != 0) && done[next_retire];   // oldest has completed

    always_comb begin
        exp_rs1 = predict(id_in.rs1_idx);
        exp_rs2 = predict(id_in.rs2_idx);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            occupancy   <= 0;
            next_retire <= '0;
            next_alloc  <= '0;
            for (int i = 0; i < `REG_LEN; i++) begin
                map_valid[i] <= 1'b0;
                regs[i]      <= '0;
            end
        end else begin
            occupancy <= occupancy + int'(rs_out.valid) - int'(retire_out.valid);
            if (retire_out.valid) begin
                next_retire <= rob_tag_t'(next_retire + 1);
                if (writes[retire_out.tag]) begin
                    regs[dest[retire_out.tag]] <= cdb_value[retire_out.tag];
                    if (map_tag[dest[retire_out.tag]] == retire_out.tag)
                        map_valid[dest[retire_out.tag]] <= 1'b0;
                end
            end
            if (cdb_in.valid) begin
                done[cdb_in.tag]      <= 1'b1;
                cdb_value[cdb_in.tag] <= cdb_in.value;
            end
            if (rs_out.valid) begin
                next_alloc         <= rob_tag_t'(next_alloc + 1);
                done[next_alloc]   <= 1'b0;
                writes[next_alloc] <= new_writes;
                dest[next_alloc]   <= id_in.dest_reg_idx;
                if (new_writes) begin   // placed after retire so dispatch wins
                    map_valid[id_in.dest_reg_idx] <= 1'b1;
                    map_tag[id_in.dest_reg_idx]   <= next_alloc;
                end
            end
        end
    end

    a_reset: assert property (@(posedge clock)
        reset |=> !stall && !rs_out.valid && !retire_out.valid)
        else begin
            $error("an output was active right after reset");
            error_count++;
        end

    a_stall: assert property (@(posedge clock) disable iff (reset)
        stall == (occupancy == `ROB_LEN))
        else begin
            $error("CHECK FAILED stall_level expected %b actual %b",
                   $sampled(occupancy == `ROB_LEN), $sampled(stall));
            error_count++;
        end

    a_accept: assert property (@(posedge clock) disable iff (reset)
        rs_out.valid == (id_in.valid && !stall))
        else begin
            $error("CHECK FAILED dispatch_accept expected %b actual %b",
                   $sampled(id_in.valid && !stall), $sampled(rs_out.valid));
            error_count++;
        end

    a_tag: assert property (@(posedge clock) disable iff (reset)
        rs_out.valid |-> rs_out.tag == next_alloc)
        else begin
            $error("CHECK FAILED dispatch_tag expected %h actual %h",
                   $sampled(next_alloc), $sampled(rs_out.tag));
            error_count++;
        end

    a_retire: assert property (@(posedge clock) disable iff (reset)
        retire_out.valid == exp_retire)
        else begin
            $error("CHECK FAILED retire_valid expected %b actual %b",
                   $sampled(exp_retire), $sampled(retire_out.valid));
            error_count++;
        end

    a_order: assert property (@(posedge clock) disable iff (reset)
        retire_out.valid |-> retire_out.tag == next_retire && ret_done)
        else begin
            $error("CHECK FAILED retire_order expected %h actual %h (completed %b)",
                   $sampled(next_retire), $sampled(retire_out.tag), $sampled(ret_done));
            error_count++;
        end

    a_value: assert property (@(posedge clock) disable iff (reset)
        retire_out.valid |-> retire_out.value == ret_value)
        else begin
            $error("CHECK FAILED retire_value expected %h actual %h",
                   $sampled(ret_value), $sampled(retire_out.value));
            error_count++;
        end

    a_dest: assert property (@(posedge clock) disable iff (reset)
        retire_out.valid |-> retire_out.writes_reg == writes[retire_out.tag]
                             && retire_out.dest_reg_idx == dest[retire_out.tag])
        else begin
            $error("CHECK FAILED retire_dest expected %b/%h actual %b/%h",
                   $sampled(writes[retire_out.tag]), $sampled(dest[retire_out.tag]),
                   $sampled(retire_out.writes_reg), $sampled(retire_out.dest_reg_idx));
            error_count++;
        end

    a_rs1: assert property (@(posedge clock) disable iff (reset)
        rs_out.valid |-> operand_ok(exp_rs1, rs_out.rs1))
        else begin
            $error("CHECK FAILED rs1_operand expected %h actual %h",
                   $sampled(exp_rs1), $sampled(rs_out.rs1));
            error_count++;
        end

    a_rs2: assert property (@(posedge clock) disable iff (reset)
        rs_out.valid |-> operand_ok(exp_rs2, rs_out.rs2))
        else begin
            $error("CHECK FAILED rs2_operand expected %h actual %h",
                   $sampled(exp_rs2), $sampled(rs_out.rs2));
            error_count++;
        end

endmodule

bind rob_top rob_chk chk0 (
    .clock      (clock),
    .reset      (reset),
    .id_in      (id_in),
    .cdb_in     (cdb_in),
    .stall      (stall),
    .rs_out     (rs_out),
    .retire_out (retire_out)
);

//--- tests/rob_tb.sv
module rob_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import rob_pkg::*;

    logic           clock;
    logic           reset;
    id_packet_t     id_in;
    cdb_packet_t    cdb_in;
    logic           stall;
    rs_packet_t     rs_out;
    retire_packet_t retire_out;

    logic [15:0] lfsr;
    rob_tag_t    outstanding [$];   // dispatched, not yet completed
    int          guard;

    rob_top dut0 (
        .clock      (clock),
        .reset      (reset),
        .id_in      (id_in),
        .cdb_in     (cdb_in),
        .stall      (stall),
        .rs_out     (rs_out),
        .retire_out (retire_out)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // galois lfsr, one step per bit
    function automatic logic rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 16'hb400;
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], rand_bit()};
        return r;
    endfunction

    task automatic abort_run(string why);
        $display("Test failures found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_errors();
        if (dut0.chk0.error_count != 0)
            abort_run("the checker reported a failed assertion");
    endtask

    // one clock of stimulus, entered 10 ns after a rising edge
    task automatic run_cycle(logic do_dispatch, logic do_complete);
        int pick;
        id_in  = '0;
        cdb_in = '0;
        if (do_dispatch && (stall || rand_bit())) begin   // always offer into a full buffer
            id_in.valid        = 1'b1;
            id_in.opcode       = opcode_t'(rand_bits(2));
            id_in.dest_reg_idx = reg_idx_t'(rand_bits(3));
            id_in.rs1_idx      = reg_idx_t'(rand_bits(3));
            id_in.rs2_idx      = reg_idx_t'(rand_bits(3));
        end
        if (do_complete && outstanding.size() > 0 && rand_bits(2) != 0) begin
            pick          = int'(rand_bits(3)) % outstanding.size();   // often out of order
            cdb_in.valid  = 1'b1;
            cdb_in.tag    = outstanding[pick];
            cdb_in.value  = rand_bits(32);
            outstanding.delete(pick);
        end
        @(negedge clock);
        if (rs_out.valid)
            outstanding.push_back(rs_out.tag);
        @(posedge clock);
        #10;
        check_errors();
    endtask

    initial begin
        lfsr   = 16'd51;
        reset  = 1'b1;
        id_in  = '0;
        cdb_in = '0;
        repeat (10) @(posedge clock);
        #10 reset = 1'b0;
        @(posedge clock);
        #10;

        // fill, nothing completes until stall rises
        guard = 0;
        while (!stall) begin
            run_cycle(1'b1, 1'b0);
            guard++;
            if (guard > 200)
                abort_run("timed out waiting for stall to rise");
        end
        repeat (6) run_cycle(1'b1, 1'b0);   // these offers get dropped

        guard = 0;
        while (outstanding.size() != 0) begin
            run_cycle(1'b0, 1'b1);
            guard++;
            if (guard > 200)
                abort_run("timed out draining the reorder buffer");
        end

        repeat (400) run_cycle(1'b1, 1'b1);

        if (dut0.chk0.error_count != 0)
            abort_run("the checker reported a failed assertion");
        else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+include
source/rob_pkg.sv
source/rename_stage.sv
source/rob_entry.sv
source/rob.sv
source/arch_regfile.sv
source/rob_top.sv
tests/rob_chk.sv
tests/rob_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, run, and decide on the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f all.f -o rob_sim &&
./obj_dir/rob_sim +verilator+error+limit+100 | tee /dev/stderr | grep -q "All tests passed!" &&
echo "PASS" || { echo "FAIL"; exit 1; }
